// File: source/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  localparam logic [11:0] csr_mtvec = 12'h305;
  localparam logic [11:0] csr_mepc = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  localparam logic [xlen-1:0] cause_ecall = 32'd11; // Environment call from M-mode.
  localparam logic [xlen-1:0] reset_mtvec = 32'h100;

  // ALU operations. The compare group returns 0 or 1 in bit 0.
  typedef enum logic [7:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_t;

  typedef enum logic [2:0] {
    npc_seq,    // pc + 4.
    npc_jump,   // pc + imm.
    npc_jalr,   // ALU result with bit 0 cleared.
    npc_branch, // Target when the compare holds.
    npc_csr     // mtvec or mepc.
  } npc_sel_t;

  typedef enum logic [1:0] {
    wdata_alu,
    wdata_link,
    wdata_target,
    wdata_csr
  } wdata_sel_t;

  typedef enum logic [1:0] {
    op2_rs2,
    op2_imm,
    op2_csr
  } operand2_sel_t;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_t;

endpackage

// File: source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_t alu_op,
  input  logic [31:0]     operand1,
  input  logic [31:0]     operand2,
  output logic [31:0]     result
);

  logic [4:0] shamt;

  assign shamt = operand2[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = operand1 + operand2;
      rv_pkg::alu_sub:  result = operand1 - operand2;
      rv_pkg::alu_and:  result = operand1 & operand2;
      rv_pkg::alu_or:   result = operand1 | operand2;
      rv_pkg::alu_xor:  result = operand1 ^ operand2;
      rv_pkg::alu_sll:  result = operand1 << shamt;
      rv_pkg::alu_srl:  result = operand1 >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(operand1) >>> shamt);
      rv_pkg::alu_slt:  result = {31'd0, $signed(operand1) < $signed(operand2)};
      rv_pkg::alu_sltu: result = {31'd0, operand1 < operand2};
      rv_pkg::alu_eq:   result = {31'd0, operand1 == operand2};
      rv_pkg::alu_ne:   result = {31'd0, operand1 != operand2};
      rv_pkg::alu_lt:   result = {31'd0, $signed(operand1) < $signed(operand2)};
      rv_pkg::alu_ge:   result = {31'd0, $signed(operand1) >= $signed(operand2)};
      rv_pkg::alu_ltu:  result = {31'd0, operand1 < operand2};
      rv_pkg::alu_geu:  result = {31'd0, operand1 >= operand2};
      default:          result = 32'd0;
    endcase
  end

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      block,
  input  logic                      inst_valid,
  input  logic [31:0]               inst,
  input  logic [31:0]               inst_pc,
  input  logic [31:0]               rs1_data,
  input  logic [31:0]               rs2_data,
  input  logic [31:0]               csr_rdata,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  output logic [11:0]               csr_raddr,
  output logic                      decode_valid,
  output logic [31:0]               pc,
  output logic [31:0]               imm,
  output logic [31:0]               src1,
  output logic [31:0]               src2,
  output logic [31:0]               csr_src,
  output rv_pkg::alu_op_t           alu_op,
  output rv_pkg::operand2_sel_t     operand2_sel,
  output rv_pkg::npc_sel_t          npc_sel,
  output rv_pkg::wdata_sel_t        wdata_sel,
  output logic [4:0]                rd_addr,
  output logic                      rd_en,
  output logic [11:0]               csr_addr,
  output logic                      csr_en,
  output logic                      is_ecall
);

  rv_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic [31:0]     imm_i;
  logic [31:0]     imm_b;
  logic [31:0]     imm_u;
  logic [31:0]     imm_j;

  logic [31:0]             next_imm;
  rv_pkg::alu_op_t         next_alu_op;
  rv_pkg::operand2_sel_t   next_op2_sel;
  rv_pkg::npc_sel_t        next_npc_sel;
  rv_pkg::wdata_sel_t      next_wdata_sel;
  logic                    writes_rd;
  logic                    next_csr_en;
  logic                    next_is_ecall;

  function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  arith_op = rv_pkg::alu_sll;
      3'b010:  arith_op = rv_pkg::alu_slt;
      3'b011:  arith_op = rv_pkg::alu_sltu;
      3'b100:  arith_op = rv_pkg::alu_xor;
      3'b101:  arith_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
  endfunction

  function automatic rv_pkg::alu_op_t branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  branch_op = rv_pkg::alu_eq;
      3'b001:  branch_op = rv_pkg::alu_ne;
      3'b100:  branch_op = rv_pkg::alu_lt;
      3'b101:  branch_op = rv_pkg::alu_ge;
      3'b110:  branch_op = rv_pkg::alu_ltu;
      default: branch_op = rv_pkg::alu_geu;
    endcase
  endfunction

  assign opcode = rv_pkg::opcode_t'(inst[6:0]);
  assign funct3 = inst[14:12];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'd0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign rs1_addr = (opcode == rv_pkg::op_lui) ? 5'd0 : inst[19:15]; // lui adds imm to x0.
  assign rs2_addr = inst[24:20];

  // ####################################################################
  // Control decode

  always_comb begin
    next_imm = imm_i;
    next_alu_op = rv_pkg::alu_add;
    next_op2_sel = rv_pkg::op2_rs2;
    next_npc_sel = rv_pkg::npc_seq;
    next_wdata_sel = rv_pkg::wdata_alu;
    writes_rd = 1'b0;
    next_csr_en = 1'b0;
    next_is_ecall = 1'b0;
    csr_raddr = inst[31:20];
    case (opcode)
      rv_pkg::op_lui: begin
        next_imm = imm_u;
        next_op2_sel = rv_pkg::op2_imm;
        writes_rd = 1'b1;
      end
      rv_pkg::op_auipc: begin
        next_imm = imm_u;
        next_wdata_sel = rv_pkg::wdata_target;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        next_imm = imm_j;
        next_npc_sel = rv_pkg::npc_jump;
        next_wdata_sel = rv_pkg::wdata_link;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jalr: begin
        next_op2_sel = rv_pkg::op2_imm;
        next_npc_sel = rv_pkg::npc_jalr;
        next_wdata_sel = rv_pkg::wdata_link;
        writes_rd = 1'b1;
      end
      rv_pkg::op_branch: begin
        next_imm = imm_b;
        next_alu_op = branch_op(funct3);
        if (funct3[2:1] != 2'b01) begin
          next_npc_sel = rv_pkg::npc_branch; // Reserved funct3 values fall through.
        end
      end
      rv_pkg::op_imm: begin
        next_op2_sel = rv_pkg::op2_imm;
        next_alu_op = arith_op(funct3, inst[30] && funct3 == 3'b101);
        writes_rd = 1'b1;
      end
      rv_pkg::op_reg: begin
        next_alu_op = arith_op(funct3, inst[30]);
        writes_rd = 1'b1;
      end
      rv_pkg::op_system: begin
        if (funct3 == 3'b001) begin
          next_imm = 32'd0; // New value is rs1 + 0.
          next_op2_sel = rv_pkg::op2_imm;
          next_wdata_sel = rv_pkg::wdata_csr;
          writes_rd = 1'b1;
          next_csr_en = 1'b1;
        end else if (funct3 == 3'b010) begin
          next_alu_op = rv_pkg::alu_or;
          next_op2_sel = rv_pkg::op2_csr;
          next_wdata_sel = rv_pkg::wdata_csr;
          writes_rd = 1'b1;
          next_csr_en = inst[19:15] != 5'd0; // csrrs with x0 only reads.
        end else if (inst == 32'h0000_0073) begin
          csr_raddr = rv_pkg::csr_mtvec;
          next_npc_sel = rv_pkg::npc_csr;
          next_is_ecall = 1'b1;
        end else if (inst == 32'h3020_0073) begin
          csr_raddr = rv_pkg::csr_mepc;
          next_npc_sel = rv_pkg::npc_csr;
        end
      end
      default: begin
      end
    endcase
  end

  // ####################################################################
  // Decode to execute registers

  always_ff @(posedge clock) begin
    if (reset) begin
      decode_valid <= 1'b0;
      rd_en <= 1'b0;
      csr_en <= 1'b0;
      is_ecall <= 1'b0;
    end else if (!block) begin
      decode_valid <= inst_valid;
      rd_en <= inst_valid && writes_rd && inst[11:7] != 5'd0;
      csr_en <= inst_valid && next_csr_en;
      is_ecall <= inst_valid && next_is_ecall;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      pc <= inst_pc;
      imm <= next_imm;
      src1 <= rs1_data;
      src2 <= rs2_data;
      csr_src <= csr_rdata;
      alu_op <= next_alu_op;
      operand2_sel <= next_op2_sel;
      npc_sel <= next_npc_sel;
      wdata_sel <= next_wdata_sel;
      rd_addr <= inst[11:7];
      csr_addr <= csr_raddr;
    end
  end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  block,
  input  logic                  decode_valid,
  input  logic [31:0]           pc,
  input  logic [31:0]           imm,
  input  logic [31:0]           src1,
  input  logic [31:0]           src2,
  input  logic [31:0]           csr_src,
  input  rv_pkg::alu_op_t       alu_op,
  input  rv_pkg::operand2_sel_t operand2_sel,
  input  rv_pkg::npc_sel_t      npc_sel,
  input  rv_pkg::wdata_sel_t    wdata_sel,
  input  logic [4:0]            rd_addr,
  input  logic                  rd_en,
  input  logic [11:0]           csr_addr,
  input  logic                  csr_en,
  input  logic                  is_ecall,
  output logic                  npc_valid,
  output logic [31:0]           npc,
  output logic                  redirect,
  output logic                  commit,
  output logic [4:0]            rd_write_addr,
  output logic                  rd_en_q,
  output logic [31:0]           exu_wdata,
  output logic [11:0]           csr_addr_q,
  output logic [31:0]           csr_wdata,
  output logic                  csr_en_q,
  output logic                  ecall_commit,
  output logic [31:0]           epc
);

  rv_pkg::alu_op_t    opcode;
  rv_pkg::npc_sel_t   npc_sel_q;
  rv_pkg::wdata_sel_t wdata_sel_q;
  logic [31:0]        operand1;
  logic [31:0]        operand2;
  logic [31:0]        snpc;
  logic [31:0]        dnpc;
  logic [31:0]        pc_q;
  logic [31:0]        csr_src_q;
  logic               is_ecall_q;
  logic [31:0]        alu_result;

  rv_alu i_alu (
    .alu_op   (opcode),
    .operand1 (operand1),
    .operand2 (operand2),
    .result   (alu_result)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid <= 1'b0;
      rd_en_q <= 1'b0;
      csr_en_q <= 1'b0;
      is_ecall_q <= 1'b0;
    end else if (!block) begin
      npc_valid <= decode_valid && !redirect; // Drops the instruction behind a redirect.
      rd_en_q <= rd_en;
      csr_en_q <= csr_en;
      is_ecall_q <= is_ecall;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      opcode <= alu_op;
      operand1 <= src1;
      case (operand2_sel)
        rv_pkg::op2_imm: operand2 <= imm;
        rv_pkg::op2_csr: operand2 <= csr_src;
        default:         operand2 <= src2;
      endcase
      snpc <= pc + 32'd4;
      dnpc <= pc + imm;
      pc_q <= pc;
      csr_src_q <= csr_src;
      npc_sel_q <= npc_sel;
      wdata_sel_q <= wdata_sel;
      rd_write_addr <= rd_addr;
      csr_addr_q <= csr_addr;
    end
  end

  always_comb begin
    case (npc_sel_q)
      rv_pkg::npc_jump:   npc = dnpc;
      rv_pkg::npc_jalr:   npc = alu_result & ~32'd1;
      rv_pkg::npc_branch: npc = alu_result[0] ? dnpc : snpc;
      rv_pkg::npc_csr:    npc = csr_src_q;
      default:            npc = snpc;
    endcase
  end

  always_comb begin
    case (wdata_sel_q)
      rv_pkg::wdata_link:   exu_wdata = snpc;
      rv_pkg::wdata_target: exu_wdata = dnpc;
      rv_pkg::wdata_csr:    exu_wdata = csr_src_q; // Old CSR value goes to rd.
      default:              exu_wdata = alu_result;
    endcase
  end

  assign redirect = npc_valid && npc != snpc;
  assign commit = npc_valid;
  assign csr_wdata = alu_result;
  assign ecall_commit = npc_valid && is_ecall_q;
  assign epc = pc_q;

  a_npc_aligned: assert property (@(posedge clock) disable iff (reset)
    npc_valid |-> npc[1:0] == 2'b00);

endmodule

// File: source/rv_result.sv
`timescale 1ns/1ps

module rv_result (
  input  logic        clock,
  input  logic        reset,
  input  logic        block,
  input  logic        commit,
  input  logic        rd_en,
  input  logic [4:0]  rd_waddr,
  input  logic [31:0] rd_wdata,
  input  logic        csr_en,
  input  logic [11:0] csr_waddr,
  input  logic [31:0] csr_wdata,
  input  logic        ecall_commit,
  input  logic [31:0] epc,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [11:0] csr_raddr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  output logic [31:0] csr_rdata
);

  logic [31:0] regs [1:31];
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic        write_enable;

  assign write_enable = commit && !block;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (write_enable && rd_en && rd_waddr != 5'd0) begin
      regs[rd_waddr] <= rd_wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtvec <= rv_pkg::reset_mtvec;
      mepc <= 32'd0;
      mcause <= 32'd0;
    end else if (write_enable) begin
      if (ecall_commit) begin
        mepc <= epc; // Both trap CSRs land on the same commit edge.
        mcause <= rv_pkg::cause_ecall;
      end else if (csr_en) begin
        case (csr_waddr)
          rv_pkg::csr_mtvec:  mtvec <= csr_wdata;
          rv_pkg::csr_mepc:   mepc <= csr_wdata;
          rv_pkg::csr_mcause: mcause <= csr_wdata;
          default: begin
          end
        endcase
      end
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

  always_comb begin
    case (csr_raddr)
      rv_pkg::csr_mtvec:  csr_rdata = mtvec;
      rv_pkg::csr_mepc:   csr_rdata = mepc;
      rv_pkg::csr_mcause: csr_rdata = mcause;
      default:            csr_rdata = 32'd0;
    endcase
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic        clock,
  input  logic        reset,
  input  logic        block,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  input  logic [31:0] inst_pc,
  output logic        npc_valid,
  output logic [31:0] npc,
  output logic        redirect,
  output logic        rd_write,
  output logic [4:0]  rd_addr,
  output logic [31:0] rd_data,
  output logic        csr_write,
  output logic [11:0] csr_addr,
  output logic [31:0] csr_data
);

  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [11:0] csr_raddr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] csr_rdata;

  logic                  decode_valid;
  logic [31:0]           pc;
  logic [31:0]           imm;
  logic [31:0]           src1;
  logic [31:0]           src2;
  logic [31:0]           csr_src;
  rv_pkg::alu_op_t       alu_op;
  rv_pkg::operand2_sel_t operand2_sel;
  rv_pkg::npc_sel_t      npc_sel;
  rv_pkg::wdata_sel_t    wdata_sel;
  logic [4:0]            dec_rd_addr;
  logic                  rd_en;
  logic [11:0]           dec_csr_addr;
  logic                  csr_en;
  logic                  is_ecall;

  logic        commit;
  logic [4:0]  rd_write_addr;
  logic        rd_en_q;
  logic [31:0] exu_wdata;
  logic [11:0] csr_addr_q;
  logic [31:0] csr_wdata;
  logic        csr_en_q;
  logic        ecall_commit;
  logic [31:0] epc;

  rv_decode i_decode (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .csr_rdata    (csr_rdata),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .csr_raddr    (csr_raddr),
    .decode_valid (decode_valid),
    .pc           (pc),
    .imm          (imm),
    .src1         (src1),
    .src2         (src2),
    .csr_src      (csr_src),
    .alu_op       (alu_op),
    .operand2_sel (operand2_sel),
    .npc_sel      (npc_sel),
    .wdata_sel    (wdata_sel),
    .rd_addr      (dec_rd_addr),
    .rd_en        (rd_en),
    .csr_addr     (dec_csr_addr),
    .csr_en       (csr_en),
    .is_ecall     (is_ecall)
  );

  rv_execute i_execute (
    .clock         (clock),
    .reset         (reset),
    .block         (block),
    .decode_valid  (decode_valid),
    .pc            (pc),
    .imm           (imm),
    .src1          (src1),
    .src2          (src2),
    .csr_src       (csr_src),
    .alu_op        (alu_op),
    .operand2_sel  (operand2_sel),
    .npc_sel       (npc_sel),
    .wdata_sel     (wdata_sel),
    .rd_addr       (dec_rd_addr),
    .rd_en         (rd_en),
    .csr_addr      (dec_csr_addr),
    .csr_en        (csr_en),
    .is_ecall      (is_ecall),
    .npc_valid     (npc_valid),
    .npc           (npc),
    .redirect      (redirect),
    .commit        (commit),
    .rd_write_addr (rd_write_addr),
    .rd_en_q       (rd_en_q),
    .exu_wdata     (exu_wdata),
    .csr_addr_q    (csr_addr_q),
    .csr_wdata     (csr_wdata),
    .csr_en_q      (csr_en_q),
    .ecall_commit  (ecall_commit),
    .epc           (epc)
  );

  rv_result i_result (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .commit       (commit),
    .rd_en        (rd_en_q),
    .rd_waddr     (rd_write_addr),
    .rd_wdata     (exu_wdata),
    .csr_en       (csr_en_q),
    .csr_waddr    (csr_addr_q),
    .csr_wdata    (csr_wdata),
    .ecall_commit (ecall_commit),
    .epc          (epc),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .csr_raddr    (csr_raddr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .csr_rdata    (csr_rdata)
  );

  assign rd_write = commit && rd_en_q && !block;
  assign rd_addr = rd_write_addr;
  assign rd_data = exu_wdata;

  // An ecall reports its mcause write on the CSR port.
  assign csr_write = commit && !block && (csr_en_q || ecall_commit);
  assign csr_addr = ecall_commit ? rv_pkg::csr_mcause : csr_addr_q;
  assign csr_data = ecall_commit ? rv_pkg::cause_ecall : csr_wdata;

endmodule

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] npc;
    logic        redirect;
    logic        rd_write;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        csr_write;
    logic [11:0] csr_addr;
    logic [31:0] csr_data;
    logic [3:0]  stall;    // Cycles of block after issue.
    logic [31:0] follower; // Issued right behind and expected to be killed.
  } row_t;

  logic        clock;
  logic        reset;
  logic        block;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        npc_valid;
  logic [31:0] npc;
  logic        redirect;
  logic        rd_write;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        csr_write;
  logic [11:0] csr_addr;
  logic [31:0] csr_data;

  row_t        rows[$];
  logic [31:0] xreg[32];
  logic [31:0] cur_pc;
  integer      seed = 84;

  rv_core i_dut (
    .clock      (clock),
    .reset      (reset),
    .block      (block),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .npc_valid  (npc_valid),
    .npc        (npc),
    .redirect   (redirect),
    .rd_write   (rd_write),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .csr_write  (csr_write),
    .csr_addr   (csr_addr),
    .csr_data   (csr_data)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ####################################################################
  // Instruction encoding and reference results

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
  endfunction

  function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ####################################################################
  // Stimulus table

  task automatic push(input logic [31:0] code, input logic [31:0] next_pc, input logic wr,
                      input logic [31:0] data, input logic csr_wr = 1'b0,
                      input logic [11:0] csr_a = 12'd0, input logic [31:0] csr_d = 32'd0,
                      input logic [3:0] stall = 4'd0, input logic [31:0] follower = 32'd0);
    row_t r;
    r.inst = code;
    r.pc = cur_pc;
    r.npc = next_pc;
    r.redirect = next_pc != cur_pc + 32'd4;
    r.rd_addr = code[11:7];
    r.rd_write = wr && code[11:7] != 5'd0; // Writes to x0 never show up.
    r.rd_data = data;
    r.csr_write = csr_wr;
    r.csr_addr = csr_a;
    r.csr_data = csr_d;
    r.stall = stall;
    r.follower = follower;
    rows.push_back(r);
    if (r.rd_write) begin
      xreg[r.rd_addr] = data;
    end
    cur_pc = next_pc;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) & 32'hffff_f000; // Rounds for the signed addi part.
    push(u_type(upper[31:12], rd, rv_pkg::op_lui), cur_pc + 32'd4, 1'b1, upper);
    push(i_type(value[11:0], rd, 3'd0, rd, rv_pkg::op_imm), cur_pc + 32'd4, 1'b1, value);
  endtask

  task automatic build_table();
    int          k;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [4:0]  rs2;
    logic [31:0] ecall_pc;
    cur_pc = 32'h1000;
    for (k = 0; k < 32; k++) begin
      xreg[k] = 32'd0;
    end
    for (k = 1; k <= 4; k++) begin
      load_reg(k[4:0], $random(seed));
    end
    for (k = 0; k < 8; k++) begin
      push(r_type(7'd0, 5'd2, 5'd1, k[2:0], 5'd5 + k[4:0]), cur_pc + 32'd4, 1'b1,
           arith_result(k[2:0], 1'b0, xreg[1], xreg[2]));
    end
    push(r_type(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd14), cur_pc + 32'd4, 1'b1,
         arith_result(3'd0, 1'b1, xreg[1], xreg[2]));
    push(r_type(7'b0100000, 5'd2, 5'd1, 3'd5, 5'd15), cur_pc + 32'd4, 1'b1,
         arith_result(3'd5, 1'b1, xreg[1], xreg[2]));
    for (k = 0; k < 8; k++) begin
      imm = $random(seed);
      if (k == 1) imm = {7'd0, imm[4:0]};
      if (k == 5) imm = {1'b0, imm[10], 5'd0, imm[4:0]}; // srli or srai.
      push(i_type(imm, 5'd3, k[2:0], 5'd16 + k[4:0], rv_pkg::op_imm), cur_pc + 32'd4, 1'b1,
           arith_result(k[2:0], k == 5 && imm[10], xreg[3], {{20{imm[11]}}, imm}));
    end
    push(u_type(20'h12345, 5'd24, rv_pkg::op_auipc), cur_pc + 32'd4, 1'b1,
         cur_pc + 32'h1234_5000);
    push(j_type(21'd32, 5'd25), cur_pc + 32'd32, 1'b1, cur_pc + 32'd4);
    load_reg(5'd26, 32'h2000);
    push(i_type(12'd9, 5'd26, 3'd0, 5'd27, rv_pkg::op_jalr), (xreg[26] + 32'd9) & ~32'd1,
         1'b1, cur_pc + 32'd4);
    for (k = 0; k < 8; k++) begin
      f3 = (k < 2 || k > 5) ? k[2:0] & 3'b001 : k[2:0] + 3'd2;
      rs2 = (k < 6) ? 5'd2 : 5'd1; // The last two compare x1 with itself.
      push(b_type(13'd16, rs2, 5'd1, f3),
           branch_taken(f3, xreg[1], xreg[rs2]) ? cur_pc + 32'd16 : cur_pc + 32'd4,
           1'b0, 32'd0);
    end
    push(i_type(12'h123, 5'd0, 3'd0, 5'd28, rv_pkg::op_imm), cur_pc + 32'd4, 1'b1, 32'h123);
    push(b_type(13'd8, 5'd0, 5'd0, 3'd0), cur_pc + 32'd8, 1'b0, 32'd0, 1'b0, 12'd0, 32'd0,
         4'd0, i_type(12'h055, 5'd0, 3'd0, 5'd28, rv_pkg::op_imm));
    push(i_type(12'd0, 5'd28, 3'd0, 5'd29, rv_pkg::op_imm), cur_pc + 32'd4, 1'b1, xreg[28]);
    push(i_type(rv_pkg::csr_mtvec, 5'd26, 3'b001, 5'd30, rv_pkg::op_system), cur_pc + 32'd4,
         1'b1, rv_pkg::reset_mtvec, 1'b1, rv_pkg::csr_mtvec, xreg[26]);
    ecall_pc = cur_pc;
    push(32'h0000_0073, xreg[26], 1'b0, 32'd0, 1'b1, rv_pkg::csr_mcause, 32'd11);
    push(32'h3020_0073, ecall_pc, 1'b0, 32'd0); // mret returns to the ecall.
    push(i_type(rv_pkg::csr_mcause, 5'd0, 3'b010, 5'd31, rv_pkg::op_system), cur_pc + 32'd4,
         1'b1, 32'd11);
    push(i_type(rv_pkg::csr_mepc, 5'd0, 3'b010, 5'd5, rv_pkg::op_system), cur_pc + 32'd4,
         1'b1, ecall_pc);
    push(i_type(12'd7, 5'd1, 3'd0, 5'd6, rv_pkg::op_imm), cur_pc + 32'd4, 1'b1,
         xreg[1] + 32'd7, 1'b0, 12'd0, 32'd0, 4'd5);
  endtask

  // ####################################################################
  // Checks and waits

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_npc(input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("FAIL npc: got 0x%h, expected 0x%h", got, expected));
    end
  endtask

  task automatic check_redirect(input logic got, input logic expected);
    if (got !== expected) begin
      abort_run($sformatf("FAIL redirect: got 0x%h, expected 0x%h", got, expected));
    end
  endtask

  task automatic check_rd(input logic wr, input logic [4:0] addr, input logic [31:0] data,
                          input row_t r);
    if (wr !== r.rd_write) begin
      abort_run($sformatf("FAIL rd_write: got 0x%h, expected 0x%h", wr, r.rd_write));
    end
    if (r.rd_write && addr !== r.rd_addr) begin
      abort_run($sformatf("FAIL rd_addr: got 0x%h, expected 0x%h", addr, r.rd_addr));
    end
    if (r.rd_write && data !== r.rd_data) begin
      abort_run($sformatf("FAIL rd_data: got 0x%h, expected 0x%h", data, r.rd_data));
    end
  endtask

  task automatic check_csr(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                           input row_t r);
    if (wr !== r.csr_write) begin
      abort_run($sformatf("FAIL csr_write: got 0x%h, expected 0x%h", wr, r.csr_write));
    end
    if (r.csr_write && addr !== r.csr_addr) begin
      abort_run($sformatf("FAIL csr_addr: got 0x%h, expected 0x%h", addr, r.csr_addr));
    end
    if (r.csr_write && data !== r.csr_data) begin
      abort_run($sformatf("FAIL csr_data: got 0x%h, expected 0x%h", data, r.csr_data));
    end
  endtask

  task automatic wait_npc_valid(input logic [31:0] pc);
    int count;
    count = 0;
    while (npc_valid !== 1'b1) begin
      if (count == 8) begin
        abort_run($sformatf("No npc_valid within 8 cycles for the instruction at 0x%h.", pc));
      end
      @(negedge clock);
      count++;
    end
  endtask

  task automatic hold_block(input logic [3:0] cycles);
    block = 1'b1;
    repeat (cycles) begin
      @(negedge clock);
      if (npc_valid !== 1'b0) begin
        abort_run("npc_valid rose while block was held high.");
      end
    end
    block = 1'b0;
  endtask

  task automatic expect_quiet();
    repeat (8) begin
      @(negedge clock);
      if (npc_valid !== 1'b0 || rd_write !== 1'b0) begin
        abort_run("The instruction behind a taken branch was not killed.");
      end
    end
  endtask

  // ####################################################################
  // Main sequence

  initial begin
    row_t r;
    reset = 1'b1;
    block = 1'b0;
    inst_valid = 1'b0;
    inst = 32'd0;
    inst_pc = 32'd0;
    build_table();
    repeat (5) @(negedge clock);
    reset = 1'b0;
    foreach (rows[i]) begin
      r = rows[i];
      @(negedge clock);
      inst = r.inst;
      inst_pc = r.pc;
      inst_valid = 1'b1;
      @(negedge clock);
      if (r.follower != 32'd0) begin
        inst = r.follower; // Back to back, so it is still in decode at the redirect.
        inst_pc = r.pc + 32'd4;
        @(negedge clock);
      end
      inst_valid = 1'b0;
      if (r.stall != 4'd0) begin
        hold_block(r.stall);
      end
      wait_npc_valid(r.pc);
      check_npc(npc, r.npc);
      check_redirect(redirect, r.redirect);
      check_rd(rd_write, rd_addr, rd_data, r);
      check_csr(csr_write, csr_addr, csr_data, r);
      if (r.follower != 32'd0) begin
        expect_quiet();
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
testbench/rv_core_tb.sv

// File: Makefile
TOP := rv_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
